// File: l2_pkg.sv
`default_nettype none

package l2_pkg;

    // fixed, the plru tree is built for four ways
    localparam int l2_ways = 4;

    // words per l1 line, as a power of two
    localparam int l1_offset_width = 2;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_wb,
        st_wb_wait,
        st_refill,
        st_refill_wait,
        st_respond
    } l2_state_t;

    // owner of the buffered request
    typedef enum logic [1:0] {
        src_none,
        src_icache,
        src_dread,
        src_dwrite
    } l2_src_t;

endpackage

`default_nettype wire

// File: l2_rbuf.sv
`timescale 1ns/1ps
`default_nettype none

module l2_rbuf #(
    parameter int index_width = 2,
    parameter int offset_width = 3,
    localparam int tag_width = 30 - index_width - offset_width
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    we,
    input  logic [31:0]             addr,
    input  logic [31:0]             wdata,
    input  logic [3:0]              wstrb,
    input  l2_pkg::l2_src_t         src,
    output logic [tag_width-1:0]    buf_tag,
    output logic [index_width-1:0]  buf_index,
    output logic [offset_width-1:0] buf_offset,
    output logic [31:0]             buf_wdata,
    output logic [3:0]              buf_wstrb,
    output l2_pkg::l2_src_t         buf_src
);
    import l2_pkg::*;

    // word address only, byte lanes come from the strobe
    logic [31:2] addr_q;

    always_ff @(posedge clk) begin
        if (we) begin
            addr_q    <= addr[31:2];
            buf_wdata <= wdata;
            buf_wstrb <= wstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            buf_src <= src_none;
        end else if (we) begin
            buf_src <= src;
        end
    end

    assign buf_offset = addr_q[offset_width+1:2];
    assign buf_index  = addr_q[offset_width+index_width+1:offset_width+2];
    assign buf_tag    = addr_q[31:offset_width+index_width+2];

endmodule

`default_nettype wire

// File: l2_tagv.sv
`timescale 1ns/1ps
`default_nettype none

module l2_tagv #(
    parameter int index_width = 2,
    parameter int offset_width = 3,
    localparam int tag_width = 30 - index_width - offset_width
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic [index_width-1:0]              index,
    input  logic [tag_width-1:0]                tag,
    input  logic                                tag_we,
    input  logic [$clog2(l2_pkg::l2_ways)-1:0]  tag_way,
    input  logic                                dirty_set,
    input  logic                                dirty_clr,
    input  logic [$clog2(l2_pkg::l2_ways)-1:0]  victim_way,
    output logic [l2_pkg::l2_ways-1:0]          hit_vec,
    output logic [l2_pkg::l2_ways-1:0]          valid_vec,
    output logic [tag_width-1:0]                victim_tag,
    output logic                                victim_dirty
);
    import l2_pkg::*;

    localparam int sets = 1 << index_width;

    logic [tag_width-1:0] tag_arr [l2_ways][sets];
    logic [l2_ways-1:0]   valid_arr [sets];
    logic [l2_ways-1:0]   dirty_arr [sets];

    always_comb begin
        for (int w = 0; w < l2_ways; w++) begin
            hit_vec[w] = valid_arr[index][w] && (tag_arr[w][index] == tag);
        end
    end

    assign valid_vec    = valid_arr[index];
    assign victim_tag   = tag_arr[victim_way][index];
    assign victim_dirty = valid_arr[index][victim_way] && dirty_arr[index][victim_way];

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_arr[tag_way][index] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < sets; s++) begin
                valid_arr[s] <= '0;
                dirty_arr[s] <= '0;
            end
        end else begin
            if (tag_we) begin
                valid_arr[index][tag_way] <= 1'b1;
            end
            // write hit marks dirty, refill leaves the line clean
            if (dirty_set) begin
                dirty_arr[index][tag_way] <= 1'b1;
            end else if (dirty_clr) begin
                dirty_arr[index][tag_way] <= 1'b0;
            end
        end
    end

    // a refill never installs a tag that is already present in the set
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(hit_vec));

endmodule

`default_nettype wire

// File: l2_data.sv
`timescale 1ns/1ps
`default_nettype none

module l2_data #(
    parameter int index_width = 2,
    parameter int offset_width = 3
) (
    input  logic                                    clk,
    input  logic                                    rstn,
    input  logic [index_width-1:0]                  index,
    input  logic [offset_width-1:0]                 offset,
    input  logic [$clog2(l2_pkg::l2_ways)-1:0]      way,
    input  logic                                    word_we,
    input  logic                                    line_we,
    input  logic [31:0]                             wdata,
    input  logic [3:0]                              wstrb,
    input  logic [(32 << offset_width)-1:0]         refill_line,
    output logic [(32 << offset_width)-1:0]         victim_line,
    output logic [(32 << l2_pkg::l1_offset_width)-1:0] rdata
);
    import l2_pkg::*;

    localparam int line_width = 32 << offset_width;
    localparam int l1_width   = 32 << l1_offset_width;

    logic [line_width-1:0] lines [l2_ways][1 << index_width];
    logic [line_width-1:0] cur_line;
    logic [line_width-1:0] merged_line;
    logic [offset_width-l1_offset_width-1:0] l1_sel;

    assign cur_line = lines[way][index];
    assign l1_sel   = offset[offset_width-1:l1_offset_width];

    // byte merge of one word under the strobe
    always_comb begin
        merged_line = cur_line;
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                merged_line[offset * 32 + b * 8 +: 8] = wdata[b * 8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_we) begin
            lines[way][index] <= refill_line;
        end else if (word_we) begin
            lines[way][index] <= merged_line;
        end
    end

    assign victim_line = cur_line;
    assign rdata       = cur_line[l1_sel * l1_width +: l1_width];

endmodule

`default_nettype wire

// File: l2_plru.sv
`timescale 1ns/1ps
`default_nettype none

module l2_plru #(
    parameter int index_width = 2
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic [index_width-1:0]              index,
    input  logic                                touch,
    input  logic [$clog2(l2_pkg::l2_ways)-1:0]  touch_way,
    input  logic [l2_pkg::l2_ways-1:0]          valid_vec,
    output logic [$clog2(l2_pkg::l2_ways)-1:0]  victim_way
);
    import l2_pkg::*;

    localparam int way_width = $clog2(l2_ways);

    // bit 0 picks the half, bit 1 the left pair, bit 2 the right pair
    logic [2:0] tree [1 << index_width];
    logic [2:0] cur;

    assign cur = tree[index];

    always_comb begin
        victim_way = {cur[0], cur[0] ? cur[2] : cur[1]};
        // lowest invalid way wins over the tree
        for (int w = l2_ways - 1; w >= 0; w--) begin
            if (!valid_vec[w]) begin
                victim_way = way_width'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < (1 << index_width); s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            tree[index][0] <= ~touch_way[1];
            if (touch_way[1]) begin
                tree[index][2] <= ~touch_way[0];
            end else begin
                tree[index][1] <= ~touch_way[0];
            end
        end
    end

endmodule

`default_nettype wire

// File: l2_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module l2_fsm #(
    parameter int index_width = 2,
    parameter int offset_width = 3
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  l2_pkg::l2_src_t                     src,
    input  l2_pkg::l2_src_t                     buf_src,
    input  logic [l2_pkg::l2_ways-1:0]          hit_vec,
    input  logic                                victim_dirty,
    input  logic [$clog2(l2_pkg::l2_ways)-1:0]  victim_way,
    input  logic                                mem_rd_addr_ok,
    input  logic                                mem_wr_addr_ok,
    input  logic                                mem_data_ok,
    output logic                                rbuf_we,
    output logic                                icache_addr_ok,
    output logic                                dcache_addr_ok,
    output logic                                icache_data_ok,
    output logic                                dcache_data_ok,
    output logic                                tag_we,
    output logic                                dirty_set,
    output logic                                dirty_clr,
    output logic                                data_word_we,
    output logic                                data_line_we,
    output logic [$clog2(l2_pkg::l2_ways)-1:0]  way_sel,
    output logic                                plru_touch,
    output logic                                mem_rd_req,
    output logic                                mem_wr_req
);
    import l2_pkg::*;

    localparam int way_width = $clog2(l2_ways);

    l2_state_t            state;
    l2_state_t            state_next;
    logic [way_width-1:0] victim_q;
    logic [way_width-1:0] hit_idx;
    logic                 hit;
    logic                 refill_done;

    // the response slices an l1 line out of the l2 line
    if (index_width < 1 || offset_width < l1_offset_width) begin : g_geom_check
        $error("cache geometry out of range");
    end

    assign hit = |hit_vec;

    always_comb begin
        hit_idx = '0;
        for (int w = 0; w < l2_ways; w++) begin
            if (hit_vec[w]) begin
                hit_idx = way_width'(w);
            end
        end
    end

    // no hit outside lookup and respond, so the latched victim applies there
    assign way_sel = hit ? hit_idx : ((state == st_lookup) ? victim_way : victim_q);

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (src != src_none) state_next = st_lookup;
            end
            st_lookup: begin
                if (hit) state_next = st_respond;
                else if (victim_dirty) state_next = st_wb;
                else state_next = st_refill;
            end
            st_wb: begin
                if (mem_wr_addr_ok) state_next = st_wb_wait;
            end
            st_wb_wait: begin
                if (mem_data_ok) state_next = st_refill;
            end
            st_refill: begin
                if (mem_rd_addr_ok) state_next = st_refill_wait;
            end
            st_refill_wait: begin
                // replay the lookup against the new line
                if (mem_data_ok) state_next = st_lookup;
            end
            st_respond: state_next = st_idle;
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_lookup && !hit) begin
            victim_q <= victim_way;
        end
    end

    assign refill_done = (state == st_refill_wait) && mem_data_ok;

    assign rbuf_we        = (state == st_idle) && (src != src_none);
    assign icache_addr_ok = (state == st_idle) && (src == src_icache);
    assign dcache_addr_ok = (state == st_idle) && (src == src_dread || src == src_dwrite);
    assign icache_data_ok = (state == st_respond) && (buf_src == src_icache);
    assign dcache_data_ok = (state == st_respond)
                            && (buf_src == src_dread || buf_src == src_dwrite);

    assign tag_we       = refill_done;
    assign data_line_we = refill_done;
    assign dirty_clr    = refill_done;
    assign data_word_we = (state == st_respond) && (buf_src == src_dwrite);
    assign dirty_set    = data_word_we;
    assign plru_touch   = (state == st_respond) || refill_done;

    assign mem_wr_req = (state == st_wb);
    assign mem_rd_req = (state == st_refill);

    a_one_mem_req: assert property (@(posedge clk) disable iff (!rstn)
        !(mem_rd_req && mem_wr_req));

    a_data_ok_in_respond: assert property (@(posedge clk) disable iff (!rstn)
        (icache_data_ok || dcache_data_ok) |-> state == st_respond);

endmodule

`default_nettype wire

// File: l2_cache.sv
`timescale 1ns/1ps
`default_nettype none

module l2_cache #(
    parameter int index_width = 2,
    parameter int offset_width = 3
) (
    input  logic        clk,
    input  logic        rstn,
    // l1 side
    input  logic        icache_req,
    input  logic [31:0] icache_addr,
    output logic        icache_addr_ok,
    output logic        icache_data_ok,
    input  logic        dcache_req,
    input  logic        dcache_wr,
    input  logic [31:0] dcache_addr,
    input  logic [31:0] dcache_wdata,
    input  logic [3:0]  dcache_wstrb,
    output logic        dcache_addr_ok,
    output logic        dcache_data_ok,
    output logic [(32 << l2_pkg::l1_offset_width)-1:0] rdata,
    // memory bridge
    output logic        mem_rd_req,
    output logic [31:0] mem_rd_addr,
    input  logic        mem_rd_addr_ok,
    input  logic [(32 << offset_width)-1:0] mem_rd_line,
    output logic        mem_wr_req,
    output logic [31:0] mem_wr_addr,
    output logic [(32 << offset_width)-1:0] mem_wr_line,
    input  logic        mem_wr_addr_ok,
    input  logic        mem_data_ok
);
    import l2_pkg::*;

    localparam int tag_width = 30 - index_width - offset_width;
    localparam int way_width = $clog2(l2_ways);

    l2_src_t                 req_src;
    logic [31:0]             req_addr;
    logic [31:0]             req_wdata;
    logic [3:0]              req_wstrb;
    l2_src_t                 buf_src;
    logic [tag_width-1:0]    buf_tag;
    logic [index_width-1:0]  buf_index;
    logic [offset_width-1:0] buf_offset;
    logic [31:0]             buf_wdata;
    logic [3:0]              buf_wstrb;
    logic [l2_ways-1:0]      hit_vec;
    logic [l2_ways-1:0]      valid_vec;
    logic [tag_width-1:0]    victim_tag;
    logic                    victim_dirty;
    logic [way_width-1:0]    victim_way;
    logic [way_width-1:0]    way_sel;
    logic                    rbuf_we;
    logic                    tag_we;
    logic                    dirty_set;
    logic                    dirty_clr;
    logic                    data_word_we;
    logic                    data_line_we;
    logic                    plru_touch;

    // data cache first, then instruction cache
    always_comb begin
        req_src   = src_none;
        req_addr  = icache_addr;
        req_wdata = '0;
        req_wstrb = '0;
        if (dcache_req) begin
            req_src   = dcache_wr ? src_dwrite : src_dread;
            req_addr  = dcache_addr;
            req_wdata = dcache_wdata;
            req_wstrb = dcache_wstrb;
        end else if (icache_req) begin
            req_src = src_icache;
        end
    end

    // line aligned, victim tag for the writeback
    assign mem_rd_addr = {buf_tag, buf_index, {(offset_width + 2){1'b0}}};
    assign mem_wr_addr = {victim_tag, buf_index, {(offset_width + 2){1'b0}}};

    l2_rbuf #(.index_width(index_width), .offset_width(offset_width)) u_rbuf (
        .clk(clk), .rstn(rstn), .we(rbuf_we),
        .addr(req_addr), .wdata(req_wdata), .wstrb(req_wstrb), .src(req_src),
        .buf_tag(buf_tag), .buf_index(buf_index), .buf_offset(buf_offset),
        .buf_wdata(buf_wdata), .buf_wstrb(buf_wstrb), .buf_src(buf_src)
    );

    l2_tagv #(.index_width(index_width), .offset_width(offset_width)) u_tagv (
        .clk(clk), .rstn(rstn), .index(buf_index), .tag(buf_tag),
        .tag_we(tag_we), .tag_way(way_sel), .dirty_set(dirty_set), .dirty_clr(dirty_clr),
        .victim_way(way_sel), .hit_vec(hit_vec), .valid_vec(valid_vec),
        .victim_tag(victim_tag), .victim_dirty(victim_dirty)
    );

    l2_data #(.index_width(index_width), .offset_width(offset_width)) u_data (
        .clk(clk), .rstn(rstn), .index(buf_index), .offset(buf_offset), .way(way_sel),
        .word_we(data_word_we), .line_we(data_line_we), .wdata(buf_wdata),
        .wstrb(buf_wstrb), .refill_line(mem_rd_line),
        .victim_line(mem_wr_line), .rdata(rdata)
    );

    l2_plru #(.index_width(index_width)) u_plru (
        .clk(clk), .rstn(rstn), .index(buf_index), .touch(plru_touch),
        .touch_way(way_sel), .valid_vec(valid_vec), .victim_way(victim_way)
    );

    l2_fsm #(.index_width(index_width), .offset_width(offset_width)) u_fsm (
        .clk(clk), .rstn(rstn), .src(req_src), .buf_src(buf_src),
        .hit_vec(hit_vec), .victim_dirty(victim_dirty), .victim_way(victim_way),
        .mem_rd_addr_ok(mem_rd_addr_ok), .mem_wr_addr_ok(mem_wr_addr_ok),
        .mem_data_ok(mem_data_ok), .rbuf_we(rbuf_we),
        .icache_addr_ok(icache_addr_ok), .dcache_addr_ok(dcache_addr_ok),
        .icache_data_ok(icache_data_ok), .dcache_data_ok(dcache_data_ok),
        .tag_we(tag_we), .dirty_set(dirty_set), .dirty_clr(dirty_clr),
        .data_word_we(data_word_we), .data_line_we(data_line_we), .way_sel(way_sel),
        .plru_touch(plru_touch), .mem_rd_req(mem_rd_req), .mem_wr_req(mem_wr_req)
    );

endmodule

`default_nettype wire

// File: tb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem #(
    parameter int line_words = 8,
    parameter int lines_n = 128
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     mem_rd_req,
    input  logic [31:0]              mem_rd_addr,
    output logic                     mem_rd_addr_ok,
    output logic [32*line_words-1:0] mem_rd_line,
    input  logic                     mem_wr_req,
    input  logic [31:0]              mem_wr_addr,
    input  logic [32*line_words-1:0] mem_wr_line,
    output logic                     mem_wr_addr_ok,
    output logic                     mem_data_ok
);
    localparam int lw = $clog2(lines_n);
    localparam int ow = $clog2(line_words) + 2;

    logic [32*line_words-1:0] lines [lines_n];
    logic [31:0]   seed = 32'd8528;
    logic [1:0]    phase = 2'd0;
    logic [3:0]    wait_cnt = 4'd0;
    logic          is_wr = 1'b0;
    logic [lw-1:0] line_idx = '0;

    function automatic logic [31:0] init_word(input logic [31:0] addr);
        return (addr * 32'h0100_0193) ^ 32'h3c6e_f372;
    endfunction

    // 1 to 8 cycles
    function automatic logic [3:0] next_delay();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {1'b0, seed[18:16]} + 4'd1;
    endfunction

    initial begin
        mem_rd_addr_ok = 1'b0;
        mem_wr_addr_ok = 1'b0;
        mem_data_ok    = 1'b0;
        mem_rd_line    = '0;
        for (int l = 0; l < lines_n; l++) begin
            for (int w = 0; w < line_words; w++) begin
                lines[l][w*32 +: 32] = init_word(32'(l * line_words * 4 + w * 4));
            end
        end
    end

    always @(posedge clk) begin
        mem_rd_addr_ok <= 1'b0;
        mem_wr_addr_ok <= 1'b0;
        mem_data_ok    <= 1'b0;
        if (!rstn) begin
            phase <= 2'd0;
        end else begin
            case (phase)
                2'd0: begin
                    if (mem_rd_req || mem_wr_req) begin
                        is_wr    <= mem_wr_req;
                        wait_cnt <= next_delay();
                        phase    <= 2'd1;
                    end
                end
                2'd1: begin
                    if (wait_cnt > 4'd1) begin
                        wait_cnt <= wait_cnt - 4'd1;
                    end else begin
                        // write data is stable while the request is held
                        if (is_wr) begin
                            mem_wr_addr_ok <= 1'b1;
                            lines[mem_wr_addr[ow+lw-1:ow]] <= mem_wr_line;
                        end else begin
                            mem_rd_addr_ok <= 1'b1;
                            line_idx <= mem_rd_addr[ow+lw-1:ow];
                        end
                        wait_cnt <= next_delay();
                        phase    <= 2'd2;
                    end
                end
                2'd2: begin
                    if (wait_cnt > 4'd1) begin
                        wait_cnt <= wait_cnt - 4'd1;
                    end else begin
                        mem_data_ok <= 1'b1;
                        if (!is_wr) begin
                            mem_rd_line <= lines[line_idx];
                        end
                        phase <= 2'd3;
                    end
                end
                // one idle cycle so the next request is a fresh one
                default: phase <= 2'd0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: tb_l2_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l2_cache;
    localparam int index_width = 2;
    localparam int offset_width = 3;
    localparam int line_bits = 32 << offset_width;
    localparam int src_i = 0;
    localparam int src_dr = 1;
    localparam int src_dw = 2;
    // requests over all tests
    localparam int n_requests = 4 + 3 + 2 + 16 + 32 + 12 + 40;

    logic                 clk = 1'b0;
    logic                 rstn = 1'b0;
    logic                 icache_req = 1'b0;
    logic [31:0]          icache_addr = '0;
    logic                 dcache_req = 1'b0;
    logic                 dcache_wr = 1'b0;
    logic [31:0]          dcache_addr = '0;
    logic [31:0]          dcache_wdata = '0;
    logic [3:0]           dcache_wstrb = '0;
    logic                 icache_addr_ok;
    logic                 icache_data_ok;
    logic                 dcache_addr_ok;
    logic                 dcache_data_ok;
    logic [127:0]         rdata;
    logic                 mem_rd_req;
    logic [31:0]          mem_rd_addr;
    logic                 mem_rd_addr_ok;
    logic [line_bits-1:0] mem_rd_line;
    logic                 mem_wr_req;
    logic [31:0]          mem_wr_addr;
    logic [line_bits-1:0] mem_wr_line;
    logic                 mem_wr_addr_ok;
    logic                 mem_data_ok;

    // word-wide view of the 4 KB test window
    logic [31:0]  shadow [1024];
    logic [31:0]  seed = 32'd8528;
    logic [31:0]  wr_addrs [16];
    int           errors = 0;
    int           checks = 0;
    int           test_base = 0;
    int           cyc = 0;
    int           accept_cyc = 0;
    int           last_lat = 0;
    int           rd_count = 0;
    int           wr_count = 0;
    int           d_done = 0;
    int           exp_src [$];
    bit           exp_wr [$];
    logic [127:0] exp_line [$];

    l2_cache #(.index_width(index_width), .offset_width(offset_width)) UUT (
        .clk(clk), .rstn(rstn),
        .icache_req(icache_req), .icache_addr(icache_addr),
        .icache_addr_ok(icache_addr_ok), .icache_data_ok(icache_data_ok),
        .dcache_req(dcache_req), .dcache_wr(dcache_wr), .dcache_addr(dcache_addr),
        .dcache_wdata(dcache_wdata), .dcache_wstrb(dcache_wstrb),
        .dcache_addr_ok(dcache_addr_ok), .dcache_data_ok(dcache_data_ok), .rdata(rdata),
        .mem_rd_req(mem_rd_req), .mem_rd_addr(mem_rd_addr), .mem_rd_addr_ok(mem_rd_addr_ok),
        .mem_rd_line(mem_rd_line), .mem_wr_req(mem_wr_req), .mem_wr_addr(mem_wr_addr),
        .mem_wr_line(mem_wr_line), .mem_wr_addr_ok(mem_wr_addr_ok), .mem_data_ok(mem_data_ok)
    );

    tb_mem #(.line_words(1 << offset_width), .lines_n(128)) u_mem (
        .clk(clk), .rstn(rstn),
        .mem_rd_req(mem_rd_req), .mem_rd_addr(mem_rd_addr), .mem_rd_addr_ok(mem_rd_addr_ok),
        .mem_rd_line(mem_rd_line), .mem_wr_req(mem_wr_req), .mem_wr_addr(mem_wr_addr),
        .mem_wr_line(mem_wr_line), .mem_wr_addr_ok(mem_wr_addr_ok), .mem_data_ok(mem_data_ok)
    );

    always #4 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] init_word(input logic [31:0] addr);
        return (addr * 32'h0100_0193) ^ 32'h3c6e_f372;
    endfunction

    function automatic logic [31:0] rand32();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed ^ (seed >> 15);
    endfunction

    // l1 line holding addr, word 0 in the low bits
    function automatic logic [127:0] expected_line(input logic [31:0] addr);
        logic [127:0] l;
        for (int i = 0; i < 4; i++) begin
            l[i*32 +: 32] = shadow[{addr[11:4], 2'(i)}];
        end
        return l;
    endfunction

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic write_shadow(input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                shadow[addr[11:2]][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    task automatic drive(input int src, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [3:0] wstrb);
        if (src == src_i) begin
            icache_req  <= 1'b1;
            icache_addr <= addr;
        end else begin
            dcache_req   <= 1'b1;
            dcache_wr    <= (src == src_dw);
            dcache_addr  <= addr;
            dcache_wdata <= wdata;
            dcache_wstrb <= wstrb;
        end
    endtask

    // the accepting edge fixes the expected data, since requests are served in order
    task automatic await_accept(input int src);
        int n;
        logic ok;
        logic [31:0] addr;
        n = 0;
        ok = 1'b0;
        while (!ok && n < 200) begin
            @(posedge clk);
            ok = (src == src_i) ? icache_addr_ok : dcache_addr_ok;
            n++;
        end
        if (!ok) begin
            errors++;
            $display("request from source %0d was not accepted within 200 cycles", src);
        end else begin
            addr = (src == src_i) ? icache_addr : dcache_addr;
            if (src == src_i) begin
                icache_req <= 1'b0;
            end else begin
                dcache_req <= 1'b0;
            end
            if (src == src_dw) begin
                write_shadow(addr, dcache_wdata, dcache_wstrb);
            end
            exp_src.push_back(src);
            exp_wr.push_back(src == src_dw);
            exp_line.push_back(expected_line(addr));
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (exp_src.size() != 0 && n < 400) begin
            @(posedge clk);
            n++;
        end
        if (exp_src.size() != 0) begin
            errors++;
            $display("no data_ok within 400 cycles of the last accepted request");
            exp_src.delete();
            exp_wr.delete();
            exp_line.delete();
        end
    endtask

    task automatic access(input int src, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] wstrb);
        @(posedge clk);
        drive(src, addr, wdata, wstrb);
        await_accept(src);
        wait_done();
    endtask

    task automatic end_test(input string name);
        $display("test %-12s %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    // response checker, sampled mid-cycle
    always @(negedge clk) begin
        if (rstn) begin
            if (icache_addr_ok || dcache_addr_ok) accept_cyc = cyc;
            if (mem_rd_req && mem_rd_addr_ok) rd_count++;
            if (mem_wr_req && mem_wr_addr_ok) wr_count++;
            if (icache_data_ok || dcache_data_ok) begin
                last_lat = cyc - accept_cyc;
                if (exp_src.size() == 0) begin
                    errors++;
                    $display("data_ok at %0t without an accepted request", $time);
                end else begin
                    check_value("data_ok source", {dcache_data_ok, icache_data_ok},
                                (exp_src[0] == src_i) ? 2'b01 : 2'b10);
                    if (!exp_wr[0]) begin
                        check_value("rdata", rdata, exp_line[0]);
                    end
                    if (dcache_data_ok) d_done++;
                    exp_src.delete(0);
                    exp_wr.delete(0);
                    exp_line.delete(0);
                end
            end
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] r;
        logic [6:0] li;
        logic [line_bits-1:0] init_l;
        logic [line_bits-1:0] shad_l;
        int rd_before;
        int wr_before;
        int d_before;
        int n_back;
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = init_word(32'(i * 4));
        end
        repeat (3) @(posedge clk);
        rstn <= 1'b1;

        @(negedge clk);
        check_value("icache_addr_ok", icache_addr_ok, 0);
        check_value("dcache_addr_ok", dcache_addr_ok, 0);
        check_value("icache_data_ok", icache_data_ok, 0);
        check_value("dcache_data_ok", dcache_data_ok, 0);
        check_value("mem_rd_req", mem_rd_req, 0);
        check_value("mem_wr_req", mem_wr_req, 0);
        for (int s = 0; s < 4; s++) begin
            rd_before = rd_count;
            access((s % 2 == 0) ? src_i : src_dr, {20'd0, 5'd1, 2'(s), 5'd0}, 0, 0);
            check_value("mem_rd_req count", rd_count - rd_before, 1);
        end
        end_test("reset");

        a = {20'd0, 5'd2, 2'd0, 5'd0};
        rd_before = rd_count;
        access(src_dr, a, 0, 0);
        check_value("mem_rd_req count", rd_count - rd_before, 1);
        access(src_dr, a, 0, 0);
        check_value("hit latency", last_lat, 2);
        // other half of the same l2 line
        access(src_i, a + 32'd16, 0, 0);
        check_value("hit latency", last_lat, 2);
        check_value("mem_rd_req count", rd_count - rd_before, 1);
        end_test("miss_hit");

        @(posedge clk);
        drive(src_i, {20'd0, 5'd3, 2'd1, 5'd0}, 0, 0);
        drive(src_dr, {20'd0, 5'd3, 2'd2, 5'd8}, 0, 0);
        d_before = d_done;
        await_accept(src_dr);
        check_value("icache_addr_ok", icache_addr_ok, 0);
        await_accept(src_i);
        check_value("dcache_data_ok count", d_done - d_before, 1);
        wait_done();
        end_test("arbitration");

        for (int i = 0; i < 16; i++) begin
            r = rand32();
            wr_addrs[i] = {22'd0, r[9:2], 2'b00};
            access(src_dw, wr_addrs[i], rand32(), r[31:28]);
        end
        for (int i = 0; i < 16; i++) begin
            access(src_i, wr_addrs[i], 0, 0);
            access(src_dr, wr_addrs[i], 0, 0);
        end
        end_test("strobe_wr");

        // six dirty tags in set 3
        wr_before = wr_count;
        for (int t = 0; t < 6; t++) begin
            a = {20'd0, 5'(20 + t), 2'd3, 3'(t), 2'b00};
            access(src_dw, a, ~shadow[a[11:2]], 4'hf);
        end
        for (int t = 0; t < 6; t++) begin
            access(src_dr, {20'd0, 5'(20 + t), 2'd3, 3'(t), 2'b00}, 0, 0);
        end
        check_value("mem_wr_req count", (wr_count - wr_before) >= 2, 1);
        n_back = 0;
        for (int t = 0; t < 6; t++) begin
            li = {5'(20 + t), 2'd3};
            for (int w = 0; w < 8; w++) begin
                init_l[w*32 +: 32] = init_word({20'd0, li, 3'(w), 2'b00});
                shad_l[w*32 +: 32] = shadow[{li, 3'(w)}];
            end
            if (u_mem.lines[li] !== init_l) begin
                n_back++;
                check_value("tb_mem line", u_mem.lines[li], shad_l);
            end
        end
        check_value("lines written back", n_back >= 2, 1);
        end_test("eviction");

        for (int i = 0; i < 40; i++) begin
            r = rand32();
            access(int'(r[29:28]) % 3, {20'd0, r[11:2], 2'b00}, rand32(), r[27:24]);
        end
        end_test("random");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (n_requests * 40 + 200) @(posedge clk);
        $display("watchdog expired after %0d cycles", n_requests * 40 + 200);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
l2_pkg.sv
l2_rbuf.sv
l2_tagv.sv
l2_data.sv
l2_plru.sv
l2_fsm.sv
l2_cache.sv
tb_mem.sv
tb_l2_cache.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the l2 cache testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_l2_cache -f list.f -o tb_l2_cache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_l2_cache > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -q "All checks passed" "$log"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
